// ==== exu_macros.svh ====
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// datapath width, RV64
`define EXU_XLEN 64

// entries per stream fifo
`define EXU_FIFO_DEPTH 4

// shift-add iterations, one multiplier bit each
`define EXU_MUL_STEPS 64

`endif

// ==== exu_pkg.sv ====
`default_nettype none

`include "exu_macros.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] xdata_t;

    // nop sits at zero so a cleared bundle does nothing
    typedef enum logic [4:0] {
        ALU_NOP    = 5'd0,
        ALU_ADD    = 5'd1,
        ALU_SUB    = 5'd2,
        ALU_PASS_A = 5'd3,
        ALU_PASS_B = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_OR     = 5'd6,
        ALU_AND    = 5'd7,
        ALU_SLL    = 5'd8,
        ALU_SRL    = 5'd9,
        ALU_SRA    = 5'd10,
        ALU_SLT    = 5'd11,
        ALU_SLTU   = 5'd12,
        ALU_EQ     = 5'd13,
        ALU_GE     = 5'd14,
        ALU_GEU    = 5'd15,
        ALU_MUL    = 5'd16,
        ALU_DIV    = 5'd17,
        ALU_DIVU   = 5'd18,
        ALU_REM    = 5'd19,
        ALU_REMU   = 5'd20
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A_PC  = 2'd0,
        SEL_A_RS1 = 2'd1
    } sel_a_e;

    typedef enum logic [1:0] {
        SEL_B_IMM = 2'd0,
        SEL_B_RS2 = 2'd1,
        SEL_B_CSR = 2'd2
    } sel_b_e;

    typedef struct packed {
        alu_op_e op;
        xdata_t  pc;
        xdata_t  rs1;
        xdata_t  rs2;
        xdata_t  csr;
        xdata_t  imm;
        sel_a_e  sel_a;
        sel_b_e  sel_b;
        logic    word;
    } exu_req_t;

    typedef struct packed {
        alu_op_e op;
        xdata_t  a;
        xdata_t  b;
        logic    word;
    } operand_t;

endpackage

`default_nettype wire

// ==== exu_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// valid/ready link, data held from valid until the transfer
interface exu_stream_if #(
    parameter type payload_t = exu_pkg::xdata_t
) ();

    logic     valid;
    logic     ready;
    payload_t data;

    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

// ==== operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module operand_select (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               req_valid,
    output logic               req_ready,
    input  exu_pkg::exu_req_t  req,
    exu_stream_if.source       out
);
    import exu_pkg::*;

    operand_t next_bundle;
    xdata_t   rs1_eff;
    logic     req_fire;

    // one-entry output register, free when empty or draining
    assign req_ready = !out.valid || out.ready;
    assign req_fire  = req_valid && req_ready;

    always_comb begin
        // word ops see only the low half of rs1
        rs1_eff = req.word ? {{(`EXU_XLEN-32){1'b0}}, req.rs1[31:0]} : req.rs1;

        next_bundle.op   = req.op;
        next_bundle.word = req.word;

        case (req.sel_a)
            SEL_A_RS1: next_bundle.a = rs1_eff;
            default:   next_bundle.a = req.pc;
        endcase

        case (req.sel_b)
            SEL_B_RS2: next_bundle.b = req.rs2;
            SEL_B_CSR: next_bundle.b = req.csr;
            default:   next_bundle.b = req.imm;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out.valid <= 1'b0;
        end else if (req_fire) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            out.data <= next_bundle;
        end
    end

endmodule

`default_nettype wire

// ==== op_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module op_fifo #(
    parameter type payload_t = exu_pkg::xdata_t,
    parameter int  depth     = `EXU_FIFO_DEPTH
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    exu_stream_if.sink   in,
    exu_stream_if.source out
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);
    localparam logic [ptr_w:0]   full_count = (ptr_w + 1)'(depth);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        next_ptr = (ptr == last_slot) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == full_count);

    // a full fifo still takes a write while the head leaves
    assign in.ready  = !full || out.ready;
    assign out.valid = (count != '0);
    assign out.data  = mem[rd_ptr];

    assign wr_en = in.valid && in.ready;
    assign rd_en = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== shift_add_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module shift_add_mul (
    input  logic            clk,
    input  logic            rst,
    input  logic            abort,
    input  logic            start,
    output logic            busy,
    input  exu_pkg::xdata_t a,
    input  exu_pkg::xdata_t b,
    output logic            done,
    output exu_pkg::xdata_t product
);
    import exu_pkg::*;

    localparam int cnt_w = (`EXU_MUL_STEPS > 1) ? $clog2(`EXU_MUL_STEPS) : 1;
    localparam logic [cnt_w-1:0] last_step = cnt_w'(`EXU_MUL_STEPS - 1);

    logic [cnt_w-1:0] step;
    xdata_t           mcand;
    xdata_t           mplier;
    xdata_t           acc;
    logic             launch;

    assign launch  = start && !busy;
    assign product = acc;

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                // last bit consumed this cycle
                if (step == last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // multiplicand walks left, multiplier walks right
    always_ff @(posedge clk) begin
        if (launch) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module alu_core (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    exu_stream_if.sink   in,
    exu_stream_if.source out
);
    import exu_pkg::*;

    localparam xdata_t min_neg = {1'b1, {(`EXU_XLEN-1){1'b0}}};

    xdata_t                     a;
    xdata_t                     b;
    logic signed [`EXU_XLEN-1:0] sa;
    logic signed [`EXU_XLEN-1:0] sb;
    logic [5:0]                 shamt;
    logic                       div_ovf;
    logic                       is_mul;
    logic                       accept;
    logic                       mul_start;
    logic                       mul_busy;
    logic                       mul_done;
    xdata_t                     mul_product;
    xdata_t                     sra_full;
    xdata_t                     sdiv_q;
    xdata_t                     sdiv_r;
    xdata_t                     alu_res;

    assign a       = in.data.a;
    assign b       = in.data.b;
    assign sa      = in.data.a;
    assign sb      = in.data.b;
    assign shamt   = in.data.b[5:0];
    assign div_ovf = (a == min_neg) && (b == '1);
    assign is_mul  = (in.data.op == ALU_MUL);

    // signed shift and divide
    assign sra_full = sa >>> shamt;
    assign sdiv_q   = sa / sb;
    assign sdiv_r   = sa % sb;

    // stall while a multiply runs or its product lands
    assign in.ready  = (!out.valid || out.ready) && !mul_busy && !mul_done;
    assign accept    = in.valid && in.ready;
    assign mul_start = accept && is_mul;

    shift_add_mul u_mul (
        .clk     (clk),
        .rst     (rst),
        .abort   (flush),
        .start   (mul_start),
        .busy    (mul_busy),
        .a       (a),
        .b       (b),
        .done    (mul_done),
        .product (mul_product)
    );

    always_comb begin
        case (in.data.op)
            ALU_ADD:    alu_res = a + b;
            ALU_SUB:    alu_res = a - b;
            ALU_PASS_A: alu_res = a;
            ALU_PASS_B: alu_res = b;
            ALU_XOR:    alu_res = a ^ b;
            ALU_OR:     alu_res = a | b;
            ALU_AND:    alu_res = a & b;
            ALU_SLL:    alu_res = a << shamt;
            ALU_SRL:    alu_res = a >> shamt;
            // word form keeps the sign of bit 31 and clears the upper half
            ALU_SRA:    alu_res = in.data.word ?
                                  {{(`EXU_XLEN-32){1'b0}}, $signed(a[31:0]) >>> shamt} :
                                  sra_full;
            ALU_SLT:    alu_res = xdata_t'(sa < sb);
            ALU_SLTU:   alu_res = xdata_t'(a < b);
            ALU_EQ:     alu_res = xdata_t'(a == b);
            ALU_GE:     alu_res = xdata_t'(sa >= sb);
            ALU_GEU:    alu_res = xdata_t'(a >= b);
            // riscv rules for zero divisor and overflow
            ALU_DIV:    alu_res = (b == '0) ? '1 : (div_ovf ? a : sdiv_q);
            ALU_DIVU:   alu_res = (b == '0) ? '1 : a / b;
            ALU_REM:    alu_res = (b == '0) ? a : (div_ovf ? '0 : sdiv_r);
            ALU_REMU:   alu_res = (b == '0) ? a : a % b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out.valid <= 1'b0;
        end else if (mul_done) begin
            out.valid <= 1'b1;
        end else if (accept && !is_mul) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done) begin
            out.data <= mul_product;
        end else if (accept && !is_mul) begin
            out.data <= alu_res;
        end
    end

endmodule

`default_nettype wire

// ==== exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            req_valid,
    output logic            req_ready,
    input  exu_pkg::alu_op_e req_op,
    input  exu_pkg::xdata_t req_pc,
    input  exu_pkg::xdata_t req_rs1,
    input  exu_pkg::xdata_t req_rs2,
    input  exu_pkg::xdata_t req_csr,
    input  exu_pkg::xdata_t req_imm,
    input  exu_pkg::sel_a_e req_sel_a,
    input  exu_pkg::sel_b_e req_sel_b,
    input  logic            req_word,
    output logic            res_valid,
    input  logic            res_ready,
    output exu_pkg::xdata_t res_data
);
    import exu_pkg::*;

    exu_req_t req;

    exu_stream_if #(.payload_t(operand_t)) sel_if  ();
    exu_stream_if #(.payload_t(operand_t)) opq_if  ();
    exu_stream_if #(.payload_t(xdata_t))   core_if ();
    exu_stream_if #(.payload_t(xdata_t))   resq_if ();

    assign req = '{op: req_op, pc: req_pc, rs1: req_rs1, rs2: req_rs2, csr: req_csr,
                   imm: req_imm, sel_a: req_sel_a, sel_b: req_sel_b, word: req_word};

    operand_select u_sel (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .out       (sel_if.source)
    );

    op_fifo #(.payload_t(operand_t)) opq (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .in    (sel_if.sink),
        .out   (opq_if.source)
    );

    alu_core u_core (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .in    (opq_if.sink),
        .out   (core_if.source)
    );

    op_fifo #(.payload_t(xdata_t)) resq (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .in    (core_if.sink),
        .out   (resq_if.source)
    );

    assign res_valid     = resq_if.valid;
    assign res_data      = resq_if.data;
    assign resq_if.ready = res_ready;

endmodule

`default_nettype wire

// ==== exu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_properties (
    input logic              clk,
    input logic              rst,
    input logic              flush,
    input logic              req_valid,
    input logic              req_ready,
    input exu_pkg::exu_req_t req,
    input logic              res_valid,
    input logic              res_ready,
    input exu_pkg::xdata_t   res_data
);

    // a stalled request keeps its contents
    req_held: assert property (@(posedge clk) disable iff (rst || flush)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request changed while the stage stalled it");

    res_held: assert property (@(posedge clk) disable iff (rst || flush)
        res_valid && !res_ready |=> res_valid && $stable(res_data))
        else $error("result changed while held back");

    flush_clears: assert property (@(posedge clk) disable iff (rst)
        flush |=> !res_valid)
        else $error("result still valid after flush");

endmodule

bind exu_top exu_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data)
);

`default_nettype wire

// ==== exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module exu_tb;
    import exu_pkg::*;

    localparam int     req_timeout   = 300;
    localparam int     drain_timeout = 4000;
    localparam xdata_t min_neg       = {1'b1, {(`EXU_XLEN-1){1'b0}}};
    localparam xdata_t max_pos       = ~min_neg;

    logic     clk;
    logic     rst;
    logic     flush;
    logic     req_valid;
    logic     req_ready;
    alu_op_e  req_op;
    xdata_t   req_pc;
    xdata_t   req_rs1;
    xdata_t   req_rs2;
    xdata_t   req_csr;
    xdata_t   req_imm;
    sel_a_e   req_sel_a;
    sel_b_e   req_sel_b;
    logic     req_word;
    logic     res_valid;
    logic     res_ready;
    xdata_t   res_data;

    logic [15:0] lfsr;
    xdata_t      exp_q [$];
    xdata_t      edges [7];

    exu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // one lfsr step per bit taken
    function automatic xdata_t rand_data();
        xdata_t v;
        v = '0;
        for (int i = 0; i < `EXU_XLEN; i++) begin
            v = {v[`EXU_XLEN-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic xdata_t model_a(input sel_a_e sel, input xdata_t pc, input xdata_t rs1,
                                       input logic word);
        if (sel != SEL_A_RS1) begin
            return pc;
        end
        return word ? (rs1 & xdata_t'(32'hffff_ffff)) : rs1;
    endfunction

    function automatic xdata_t model_b(input sel_b_e sel, input xdata_t rs2, input xdata_t csr,
                                       input xdata_t imm);
        case (sel)
            SEL_B_RS2: return rs2;
            SEL_B_CSR: return csr;
            default:   return imm;
        endcase
    endfunction

    function automatic xdata_t model_result(input alu_op_e op, input xdata_t a, input xdata_t b,
                                            input logic word);
        logic [5:0]  sh;
        logic [31:0] w;
        logic        lt;
        xdata_t      ma;
        xdata_t      mb;
        xdata_t      q;
        xdata_t      r;
        sh = b[5:0];
        // signed order by flipping the sign bits
        lt = (a ^ min_neg) < (b ^ min_neg);
        ma = a[`EXU_XLEN-1] ? -a : a;
        mb = b[`EXU_XLEN-1] ? -b : b;
        q  = '0;
        r  = '0;
        if (mb != '0) begin
            q = ma / mb;
            r = ma % mb;
        end
        if (a[`EXU_XLEN-1] != b[`EXU_XLEN-1]) begin
            q = -q;
        end
        if (a[`EXU_XLEN-1]) begin
            r = -r;
        end
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_PASS_A: return a;
            ALU_PASS_B: return b;
            ALU_XOR:    return a ^ b;
            ALU_OR:     return a | b;
            ALU_AND:    return a & b;
            ALU_SLL:    return a << sh;
            ALU_SRL:    return a >> sh;
            ALU_SRA: begin
                if (word) begin
                    w = a[31:0] >> sh;
                    if (a[31]) begin
                        w = w | ~(32'hffff_ffff >> sh);
                    end
                    return {{(`EXU_XLEN-32){1'b0}}, w};
                end
                if (a[`EXU_XLEN-1]) begin
                    return (a >> sh) | ~({`EXU_XLEN{1'b1}} >> sh);
                end
                return a >> sh;
            end
            ALU_SLT:    return xdata_t'(lt);
            ALU_SLTU:   return xdata_t'(a < b);
            ALU_EQ:     return xdata_t'(a == b);
            ALU_GE:     return xdata_t'(!lt);
            ALU_GEU:    return xdata_t'(!(a < b));
            ALU_MUL:    return a * b;
            ALU_DIV:    return (b == '0) ? '1 : ((a == min_neg && b == '1) ? a : q);
            ALU_DIVU:   return (b == '0) ? '1 : a / b;
            ALU_REM:    return (b == '0) ? a : ((a == min_neg && b == '1) ? '0 : r);
            ALU_REMU:   return (b == '0) ? a : a % b;
            default:    return '0;
        endcase
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(input xdata_t got, input xdata_t exp, input string msg);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t ns: %s, got %h expected %h",
                               $time, msg, got, exp));
        end
    endtask

    task automatic check_ready_state(input logic exp_ready, input logic exp_valid,
                                     input string msg);
        if (req_ready !== exp_ready || res_valid !== exp_valid) begin
            fail_now($sformatf("CHECK FAILED at %0t ns: %s, req_ready %b res_valid %b",
                               $time, msg, req_ready, res_valid));
        end
    endtask

    // one expected value per result transfer
    always @(posedge clk) begin
        if (!rst && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                fail_now($sformatf("result %h came out at %0t ns with no request pending",
                                   res_data, $time));
            end else begin
                check_data(res_data, exp_q.pop_front(), "result data");
            end
        end
    end

    task automatic send_req(input alu_op_e op, input xdata_t pc, input xdata_t rs1,
                            input xdata_t rs2, input xdata_t csr, input xdata_t imm,
                            input sel_a_e sel_a, input sel_b_e sel_b, input logic word);
        int waited;
        exp_q.push_back(model_result(op, model_a(sel_a, pc, rs1, word),
                                     model_b(sel_b, rs2, csr, imm), word));
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = op;
        req_pc    = pc;
        req_rs1   = rs1;
        req_rs2   = rs2;
        req_csr   = csr;
        req_imm   = imm;
        req_sel_a = sel_a;
        req_sel_b = sel_b;
        req_word  = word;
        waited    = 0;
        @(posedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > req_timeout) begin
                fail_now("timed out waiting for the stage to accept a request");
            end
            @(posedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic issue_ab(input alu_op_e op, input xdata_t a, input xdata_t b,
                            input logic word);
        send_req(op, rand_data(), a, b, rand_data(), rand_data(), SEL_A_RS1, SEL_B_RS2, word);
    endtask

    task automatic wait_drained(input string where);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > drain_timeout) begin
                fail_now({"timed out waiting for results in ", where});
            end
        end
    endtask

    task automatic test_arith();
        alu_op_e ops [7];
        sel_a_e  sel_as [2];
        sel_b_e  sel_bs [3];
        ops    = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS_A, ALU_PASS_B};
        sel_as = '{SEL_A_PC, SEL_A_RS1};
        sel_bs = '{SEL_B_IMM, SEL_B_RS2, SEL_B_CSR};
        foreach (ops[k]) begin
            foreach (sel_as[i]) begin
                foreach (sel_bs[j]) begin
                    send_req(ops[k], rand_data(), rand_data(), rand_data(), rand_data(),
                             rand_data(), sel_as[i], sel_bs[j], 1'b0);
                end
            end
            // word drops the upper half of rs1 but not of pc
            send_req(ops[k], rand_data(), rand_data() | min_neg, rand_data(), rand_data(),
                     rand_data(), SEL_A_RS1, SEL_B_RS2, 1'b1);
            send_req(ops[k], rand_data() | min_neg, rand_data(), rand_data(), rand_data(),
                     rand_data(), SEL_A_PC, SEL_B_IMM, 1'b1);
        end
        wait_drained("arithmetic and logic");
    endtask

    task automatic test_shift_cmp();
        alu_op_e ops [8];
        ops = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_GE, ALU_GEU};
        foreach (ops[k]) begin
            foreach (edges[i]) begin
                foreach (edges[j]) begin
                    issue_ab(ops[k], edges[i], edges[j], 1'b0);
                end
            end
            for (int n = 0; n < 6; n++) begin
                issue_ab(ops[k], rand_data(), rand_data(), 1'b0);
            end
        end
        foreach (edges[i]) begin
            issue_ab(ALU_SRA, edges[i], rand_data(), 1'b1);
            issue_ab(ALU_SRA, rand_data(), edges[i], 1'b1);
        end
        wait_drained("shift and compare");
    endtask

    task automatic test_mul();
        for (int n = 0; n < 8; n++) begin
            issue_ab(ALU_MUL, rand_data(), rand_data(), 1'b0);
        end
        issue_ab(ALU_MUL, '1, '1, 1'b0);
        issue_ab(ALU_MUL, min_neg, xdata_t'(2), 1'b0);
        // short ops queued right behind a multiply
        issue_ab(ALU_MUL, rand_data(), rand_data(), 1'b0);
        issue_ab(ALU_ADD, rand_data(), rand_data(), 1'b0);
        issue_ab(ALU_XOR, rand_data(), rand_data(), 1'b0);
        issue_ab(ALU_MUL, rand_data(), rand_data(), 1'b0);
        issue_ab(ALU_SUB, rand_data(), rand_data(), 1'b0);
        wait_drained("multiply");
    endtask

    task automatic test_div();
        alu_op_e ops [4];
        ops = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
        foreach (ops[k]) begin
            for (int n = 0; n < 6; n++) begin
                issue_ab(ops[k], rand_data(), rand_data(), 1'b0);
            end
            issue_ab(ops[k], rand_data(), xdata_t'(7), 1'b0);
            issue_ab(ops[k], rand_data(), -xdata_t'(3), 1'b0);
            issue_ab(ops[k], -xdata_t'(7), xdata_t'(2), 1'b0);
            issue_ab(ops[k], rand_data(), '0, 1'b0);
            issue_ab(ops[k], min_neg, '1, 1'b0);
        end
        wait_drained("division");
    endtask

    task automatic test_backpressure();
        int waited;
        @(negedge clk);
        res_ready = 1'b0;
        fork
            begin
                for (int n = 0; n < 12; n++) begin
                    issue_ab((n % 2 == 0) ? ALU_ADD : ALU_XOR, rand_data(), rand_data(), 1'b0);
                end
            end
            begin
                waited = 0;
                @(negedge clk);
                while (req_ready) begin
                    waited++;
                    if (waited > 100) begin
                        fail_now("req_ready never dropped while results were held back");
                    end
                    @(negedge clk);
                end
                check_ready_state(1'b0, 1'b1, "stage full");
                repeat (20) @(negedge clk);
                check_ready_state(1'b0, 1'b1, "stage still full");
                res_ready = 1'b1;
            end
        join
        wait_drained("back-pressure");
    endtask

    task automatic test_flush();
        issue_ab(ALU_MUL, rand_data(), rand_data(), 1'b0);
        issue_ab(ALU_ADD, rand_data(), rand_data(), 1'b0);
        issue_ab(ALU_SUB, rand_data(), rand_data(), 1'b0);
        // well inside the multiply
        repeat (10) @(negedge clk);
        check_ready_state(1'b1, 1'b0, "multiply running");
        flush = 1'b1;
        exp_q.delete();
        @(negedge clk);
        flush = 1'b0;
        check_ready_state(1'b1, 1'b0, "after flush");
        // the collector rejects anything left over
        repeat (100) @(negedge clk);
        check_ready_state(1'b1, 1'b0, "idle after flush");
        issue_ab(ALU_ADD, rand_data(), rand_data(), 1'b0);
        issue_ab(ALU_MUL, rand_data(), rand_data(), 1'b0);
        wait_drained("after flush");
    endtask

    initial begin
        rst         = 1'b1;
        flush       = 1'b0;
        req_valid   = 1'b0;
        req_op      = ALU_NOP;
        req_pc      = '0;
        req_rs1     = '0;
        req_rs2     = '0;
        req_csr     = '0;
        req_imm     = '0;
        req_sel_a   = SEL_A_RS1;
        req_sel_b   = SEL_B_RS2;
        req_word    = 1'b0;
        res_ready   = 1'b1;
        lfsr        = 16'd61433;
        edges = '{'0, xdata_t'(1), '1, min_neg, max_pos, xdata_t'(32'h8000_0000),
                  xdata_t'(36)};
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_ready_state(1'b1, 1'b0, "after reset");
        test_arith();
        test_shift_cmp();
        test_mul();
        test_div();
        test_backpressure();
        test_flush();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exu.f ====
+incdir+.
exu_pkg.sv
exu_stream_if.sv
operand_select.sv
op_fifo.sv
shift_add_mul.sv
alu_core.sv
exu_top.sv
exu_properties.sv
exu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f exu.f --top-module exu_tb -Mdir obj_dir -o exu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/exu_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

exit 0
